// File: logic/alu_op_decoder.sv
`timescale 1ns/10ps

module alu_op_decoder
    import thumb_ctrl_pkg::*;
(
    input  instr_t instruction_i,
    output ctrl_t  shift_ctrl_o,
    output ctrl_t  dp_ctrl_o
);

    // shift, add, subtract, move and compare forms, keyed on bits 13 to 9
    always_comb begin
        shift_ctrl_o = CTRL_NOP;
        shift_ctrl_o.update_flags = 1'b1;
        shift_ctrl_o.reg_write = 1'b1;

        casez (instruction_i[13:9])
            5'b000??: begin
                shift_ctrl_o.alu_op = ALU_LSL;
                shift_ctrl_o.alu_b_src = SRC_IMM;
            end
            5'b001??: begin
                shift_ctrl_o.alu_op = ALU_LSR;
                shift_ctrl_o.alu_b_src = SRC_IMM;
            end
            5'b010??: begin
                shift_ctrl_o.alu_op = ALU_ASR;
                shift_ctrl_o.alu_b_src = SRC_IMM;
            end
            5'b01100: shift_ctrl_o.alu_op = ALU_ADD;
            5'b01101: shift_ctrl_o.alu_op = ALU_SUB;
            5'b01110, 5'b110??: begin
                shift_ctrl_o.alu_op = ALU_ADD;
                shift_ctrl_o.alu_b_src = SRC_IMM;
            end
            5'b01111, 5'b111??: begin
                shift_ctrl_o.alu_op = ALU_SUB;
                shift_ctrl_o.alu_b_src = SRC_IMM;
            end
            5'b100??: begin
                // move is computed as 0 + imm8
                shift_ctrl_o.alu_a_src = SRC_ZERO;
                shift_ctrl_o.alu_b_src = SRC_IMM;
            end
            5'b101??: begin
                shift_ctrl_o.alu_op = ALU_SUB;
                shift_ctrl_o.alu_b_src = SRC_IMM;
                shift_ctrl_o.reg_write = 1'b0;
            end
            default: ;
        endcase
    end

    // register data-processing, keyed on bits 9 to 6
    always_comb begin
        dp_ctrl_o = CTRL_NOP;
        dp_ctrl_o.update_flags = 1'b1;
        dp_ctrl_o.reg_write = 1'b1;

        case (instruction_i[9:6])
            4'b0000: dp_ctrl_o.alu_op = ALU_AND;
            4'b0001: dp_ctrl_o.alu_op = ALU_XOR;
            4'b0010: dp_ctrl_o.alu_op = ALU_LSL;
            4'b0011: dp_ctrl_o.alu_op = ALU_LSR;
            4'b0100: dp_ctrl_o.alu_op = ALU_ASR;
            4'b0101: dp_ctrl_o.alu_op = ALU_ADC;
            4'b0110: dp_ctrl_o.alu_op = ALU_SBC;
            4'b0111: dp_ctrl_o.alu_op = ALU_ROR;
            4'b1000: begin
                // test only sets flags from the and
                dp_ctrl_o.alu_op = ALU_AND;
                dp_ctrl_o.reg_write = 1'b0;
            end
            4'b1001: begin
                // reverse subtract is 0 - rm
                dp_ctrl_o.alu_op = ALU_SUB;
                dp_ctrl_o.alu_a_src = SRC_ZERO;
            end
            4'b1010: begin
                dp_ctrl_o.alu_op = ALU_SUB;
                dp_ctrl_o.reg_write = 1'b0;
            end
            4'b1011: begin
                dp_ctrl_o.alu_op = ALU_ADD;
                dp_ctrl_o.reg_write = 1'b0;
            end
            4'b1100: dp_ctrl_o.alu_op = ALU_OR;
            4'b1101: dp_ctrl_o.alu_op = ALU_MUL;
            4'b1110: dp_ctrl_o.alu_op = ALU_BIC;
            4'b1111: dp_ctrl_o.alu_op = ALU_NOT;
        endcase
    end

endmodule

// File: logic/mem_op_decoder.sv
`timescale 1ns/10ps

module mem_op_decoder
    import thumb_ctrl_pkg::*;
(
    input  instr_t instruction_i,
    output ctrl_t  mem_ctrl_o
);

    logic reg_form;
    logic is_load;

    // the register-offset group sits at 0101, every other form carries an immediate
    assign reg_form = (instruction_i[15:12] == 4'b0101);

    // in the register-offset group the sign-extending loads have bit 11 low
    // and bits 10 to 9 both set
    always_comb begin
        if (reg_form) begin
            is_load = instruction_i[11] || (instruction_i[10:9] == 2'b11);
        end else begin
            is_load = instruction_i[11];
        end
    end

    always_comb begin
        mem_ctrl_o = CTRL_NOP;

        if (!reg_form) begin
            mem_ctrl_o.alu_b_src = SRC_IMM;
        end

        if (is_load) begin
            mem_ctrl_o.mem_read = 1'b1;
            mem_ctrl_o.reg_write = 1'b1;
            mem_ctrl_o.data_src = DATA_FROM_MEM;
        end else begin
            mem_ctrl_o.mem_write = 1'b1;
            // both register ports hold the address operands here,
            // so the store data comes from the third read port
            mem_ctrl_o.store_sel = reg_form;
        end
    end

endmodule

// File: logic/multi_reg_if.sv
`timescale 1ns/10ps
`include "thumb_ctrl_defs.svh"

interface multi_reg_if
    import thumb_ctrl_pkg::*;
();

    // request side, from the instruction currently held
    logic      start;
    logic      descending;
    reg_list_t reg_list;
    reg_addr_t base_reg;

    // sequencer answer for the current cycle
    logic      busy;
    reg_addr_t cur_reg;
    word_t     offset;
    logic      base_writeback;

    modport ctrl_side (
        output start, descending, reg_list, base_reg,
        input  busy, cur_reg, offset, base_writeback
    );

    modport seq_side (
        input  start, descending, reg_list, base_reg,
        output busy, cur_reg, offset, base_writeback
    );

endinterface

// File: logic/reg_list_sequencer.sv
`timescale 1ns/10ps
`include "thumb_ctrl_defs.svh"

module reg_list_sequencer
    import thumb_ctrl_pkg::*;
(
    input logic           clk_i,
    input logic           reset_i,
    multi_reg_if.seq_side seq_side
);

    // registers of the list that have not been transferred yet
    reg_list_t remaining_q;
    count_t    count_q;

    reg_list_t pending;
    reg_list_t pick_mask;
    reg_addr_t pick_reg;
    count_t    list_count;
    count_t    step;
    logic      base_in_list;

    assign pending = seq_side.start ? (seq_side.reg_list & remaining_q) : '0;
    assign seq_side.busy = |pending;

    // lowest pending register for stores, highest for loads
    always_comb begin
        pick_reg = '0;
        if (seq_side.descending) begin
            for (int i = 0; i < `LIST_WIDTH; i++) begin
                if (pending[i]) begin
                    pick_reg = reg_addr_t'(i);
                end
            end
        end else begin
            for (int i = `LIST_WIDTH - 1; i >= 0; i--) begin
                if (pending[i]) begin
                    pick_reg = reg_addr_t'(i);
                end
            end
        end
    end

    assign pick_mask = reg_list_t'(1) << pick_reg;
    assign seq_side.cur_reg = pick_reg;

    always_comb begin
        list_count = '0;
        for (int i = 0; i < `LIST_WIDTH; i++) begin
            list_count = list_count + count_t'(seq_side.reg_list[i]);
        end
    end

    // loads fill from the top of the block down, the final cycle moves the base past it
    always_comb begin
        if (!seq_side.busy) begin
            step = list_count;
        end else if (seq_side.descending) begin
            step = list_count - count_q - 1'b1;
        end else begin
            step = count_q;
        end
    end

    assign seq_side.offset = word_t'(`WORD_BYTES) * word_t'(step);

    // a loaded base register keeps the loaded value instead of the written-back address
    assign base_in_list = seq_side.reg_list[seq_side.base_reg[2:0]];
    assign seq_side.base_writeback = !seq_side.descending || !base_in_list;

    // clearing whenever busy drops lets the next transfer start from a fresh mask
    always_ff @(posedge clk_i) begin
        if (reset_i || !seq_side.busy) begin
            remaining_q <= '1;
            count_q <= '0;
        end else begin
            remaining_q <= remaining_q & ~pick_mask;
            count_q <= count_q + 1'b1;
        end
    end

endmodule

// File: logic/thumb_controller.sv
`timescale 1ns/10ps

module thumb_controller
    import thumb_ctrl_pkg::*;
(
    input  logic          clk_i,
    input  logic          reset_i,
    input  instr_t        instruction_i,
    output logic          valid_o,
    output logic          update_flags_o,
    output logic          reg_write_o,
    output logic          mem_read_o,
    output logic          mem_write_o,
    output reg_data_src_t reg_data_src_o,
    output alu_src_t      alu_a_sel_o,
    output alu_src_t      alu_b_sel_o,
    output alu_op_t       alu_op_o,
    output logic          store_sel_o,
    output logic          stall_o,
    output addr_src_t     src_addr_src_o,
    output addr_src_t     dest_addr_src_o,
    output reg_addr_t     reg_addr_o,
    output word_t         offset_o
);

    op_group_t group;
    ctrl_t     shift_ctrl;
    ctrl_t     dp_ctrl;
    ctrl_t     mem_ctrl;
    ctrl_t     sel_ctrl;

    multi_reg_if mr_if ();

    // opcode group from the top six bits
    always_comb begin
        casez (instruction_i[15:10])
            6'b00????: group = GRP_SHIFT_IMM;
            6'b010000: group = GRP_DATA_PROC;
            6'b0101??: group = GRP_LS_REG;
            6'b011???, 6'b1000??, 6'b1001??: group = GRP_LS_IMM;
            6'b11000?: group = GRP_STM;
            6'b11001?: group = GRP_LDM;
            default: group = GRP_INVALID;
        endcase
    end

    assign mr_if.start = (group == GRP_STM) || (group == GRP_LDM);
    assign mr_if.descending = (group == GRP_LDM);
    assign mr_if.reg_list = instruction_i[7:0];
    assign mr_if.base_reg = reg_addr_t'(instruction_i[10:8]);

    alu_op_decoder i_alu_op_decoder (
        .instruction_i (instruction_i),
        .shift_ctrl_o  (shift_ctrl),
        .dp_ctrl_o     (dp_ctrl)
    );

    mem_op_decoder i_mem_op_decoder (
        .instruction_i (instruction_i),
        .mem_ctrl_o    (mem_ctrl)
    );

    reg_list_sequencer i_reg_list_sequencer (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .seq_side (mr_if.seq_side)
    );

    always_comb begin
        sel_ctrl = CTRL_NOP;
        src_addr_src_o = ADDR_FROM_INSTR;
        dest_addr_src_o = ADDR_FROM_INSTR;
        reg_addr_o = '0;
        offset_o = '0;

        case (group)
            GRP_SHIFT_IMM: sel_ctrl = shift_ctrl;
            GRP_DATA_PROC: sel_ctrl = dp_ctrl;
            GRP_LS_REG, GRP_LS_IMM: sel_ctrl = mem_ctrl;
            GRP_STM, GRP_LDM: begin
                // address is base + offset for every step of the transfer
                sel_ctrl.alu_b_src = SRC_OFFSET;
                offset_o = mr_if.offset;
                if (mr_if.busy) begin
                    reg_addr_o = mr_if.cur_reg;
                    if (mr_if.descending) begin
                        sel_ctrl.mem_read = 1'b1;
                        sel_ctrl.reg_write = 1'b1;
                        sel_ctrl.data_src = DATA_FROM_MEM;
                        dest_addr_src_o = ADDR_FROM_CTRL;
                    end else begin
                        sel_ctrl.mem_write = 1'b1;
                        src_addr_src_o = ADDR_FROM_CTRL;
                    end
                end else begin
                    // final cycle updates the base with the total block size
                    reg_addr_o = mr_if.base_reg;
                    sel_ctrl.reg_write = mr_if.base_writeback;
                    dest_addr_src_o = ADDR_FROM_CTRL;
                end
            end
            default: ;
        endcase
    end

    assign valid_o = (group != GRP_INVALID);
    assign stall_o = mr_if.busy;
    assign update_flags_o = sel_ctrl.update_flags;
    assign reg_write_o = sel_ctrl.reg_write;
    assign mem_read_o = sel_ctrl.mem_read;
    assign mem_write_o = sel_ctrl.mem_write;
    assign reg_data_src_o = sel_ctrl.data_src;
    assign alu_a_sel_o = sel_ctrl.alu_a_src;
    assign alu_b_sel_o = sel_ctrl.alu_b_src;
    assign alu_op_o = sel_ctrl.alu_op;
    assign store_sel_o = sel_ctrl.store_sel;

endmodule

// File: logic/thumb_ctrl_defs.svh
`ifndef THUMB_CTRL_DEFS_SVH
`define THUMB_CTRL_DEFS_SVH

// width of one Thumb instruction word
`define INSTR_WIDTH     16

// width of a data word and of the offsets handed to the ALU
`define WORD_WIDTH      32

// register numbers cover r0 to r15
`define REG_ADDR_WIDTH  4

// multiple transfers only list the eight low registers
`define LIST_WIDTH      8

// each transferred register moves the address by one word
`define WORD_BYTES      4

// wide enough to count a full list of eight
`define COUNT_WIDTH     4

`endif

// File: logic/thumb_ctrl_pkg.sv
`include "thumb_ctrl_defs.svh"

package thumb_ctrl_pkg;

    typedef logic [`INSTR_WIDTH-1:0]    instr_t;
    typedef logic [`WORD_WIDTH-1:0]     word_t;
    typedef logic [`REG_ADDR_WIDTH-1:0] reg_addr_t;
    typedef logic [`LIST_WIDTH-1:0]     reg_list_t;
    typedef logic [`COUNT_WIDTH-1:0]    count_t;

    // instruction groups that this unit decodes
    typedef enum logic [2:0] {
        GRP_SHIFT_IMM,
        GRP_DATA_PROC,
        GRP_LS_REG,
        GRP_LS_IMM,
        GRP_STM,
        GRP_LDM,
        GRP_INVALID
    } op_group_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOT,
        ALU_BIC,
        ALU_MUL,
        ALU_LSL,
        ALU_LSR,
        ALU_ASR,
        ALU_ROR,
        ALU_ADC,
        ALU_SBC
    } alu_op_t;

    // offset means the value on offset_o from the multiple-transfer sequencer
    typedef enum logic [1:0] {
        SRC_REG,
        SRC_IMM,
        SRC_ZERO,
        SRC_OFFSET
    } alu_src_t;

    typedef enum logic {
        DATA_FROM_ALU,
        DATA_FROM_MEM
    } reg_data_src_t;

    typedef enum logic {
        ADDR_FROM_INSTR,
        ADDR_FROM_CTRL
    } addr_src_t;

    // store_sel high picks register 3 as the store data
    typedef struct packed {
        logic          update_flags;
        logic          reg_write;
        logic          mem_read;
        logic          mem_write;
        reg_data_src_t data_src;
        alu_src_t      alu_a_src;
        alu_src_t      alu_b_src;
        alu_op_t       alu_op;
        logic          store_sel;
    } ctrl_t;

    // all enables off, register operands, plain add
    localparam ctrl_t CTRL_NOP = '{
        update_flags: 1'b0,
        reg_write:    1'b0,
        mem_read:     1'b0,
        mem_write:    1'b0,
        data_src:     DATA_FROM_ALU,
        alu_a_src:    SRC_REG,
        alu_b_src:    SRC_REG,
        alu_op:       ALU_ADD,
        store_sel:    1'b0
    };

endpackage

// File: testbench/tb_thumb_controller.sv
`timescale 1ns/10ps
`include "thumb_ctrl_defs.svh"

module tb_thumb_controller
    import thumb_ctrl_pkg::*;
();

    // 200 data-processing words, about 80 single-cycle words and 44 multiple
    // transfers of at most nine cycles each stay far below this
    localparam int MAX_CYCLES = 3000;

    logic          clk_i;
    logic          reset_i;
    instr_t        instruction_i;
    logic          valid_o;
    logic          update_flags_o;
    logic          reg_write_o;
    logic          mem_read_o;
    logic          mem_write_o;
    reg_data_src_t reg_data_src_o;
    alu_src_t      alu_a_sel_o;
    alu_src_t      alu_b_sel_o;
    alu_op_t       alu_op_o;
    logic          store_sel_o;
    logic          stall_o;
    addr_src_t     src_addr_src_o;
    addr_src_t     dest_addr_src_o;
    reg_addr_t     reg_addr_o;
    word_t         offset_o;

    int     errors = 0;
    int     checks = 0;
    int     cycle_count = 0;
    integer seed = 3961;

    thumb_controller i_thumb_controller (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .instruction_i   (instruction_i),
        .valid_o         (valid_o),
        .update_flags_o  (update_flags_o),
        .reg_write_o     (reg_write_o),
        .mem_read_o      (mem_read_o),
        .mem_write_o     (mem_write_o),
        .reg_data_src_o  (reg_data_src_o),
        .alu_a_sel_o     (alu_a_sel_o),
        .alu_b_sel_o     (alu_b_sel_o),
        .alu_op_o        (alu_op_o),
        .store_sel_o     (store_sel_o),
        .stall_o         (stall_o),
        .src_addr_src_o  (src_addr_src_o),
        .dest_addr_src_o (dest_addr_src_o),
        .reg_addr_o      (reg_addr_o),
        .offset_o        (offset_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic report_error(input string msg);
        errors++;
        $display("** Error at %0t: %s", $time, msg);
    endtask

    task automatic check(input logic cond, input string msg);
        checks++;
        assert (cond) else report_error(msg);
    endtask

    // an out-of-scope opcode must never enable anything
    assert property (@(posedge clk_i) !valid_o |->
        !(stall_o || reg_write_o || mem_read_o || mem_write_o || update_flags_o))
        else report_error("invalid opcode drove an enable or a stall");

    assert property (@(posedge clk_i) reset_i |-> !stall_o)
        else report_error("stall high during reset");

    task automatic drive(input instr_t word);
        @(posedge clk_i);
        #1;
        instruction_i = word;
    endtask

    // test, compare and compare-negative reuse the and, sub and add operations
    function automatic alu_op_t expected_dp_op(input logic [3:0] code);
        case (code)
            4'h0, 4'h8: return ALU_AND;
            4'h1: return ALU_XOR;
            4'h2: return ALU_LSL;
            4'h3: return ALU_LSR;
            4'h4: return ALU_ASR;
            4'h5: return ALU_ADC;
            4'h6: return ALU_SBC;
            4'h7: return ALU_ROR;
            4'h9, 4'hA: return ALU_SUB;
            4'hB: return ALU_ADD;
            4'hC: return ALU_OR;
            4'hD: return ALU_MUL;
            4'hE: return ALU_BIC;
            default: return ALU_NOT;
        endcase
    endfunction

    task automatic sweep_data_processing();
        instr_t     word;
        logic [3:0] code;
        for (int k = 0; k < 200; k++) begin
            word = {6'b010000, 10'($random(seed))};
            code = word[9:6];
            drive(word);
            @(negedge clk_i);
            check(alu_op_o == expected_dp_op(code),
                $sformatf("data processing code %h gave ALU op %0d", code, alu_op_o));
            check(update_flags_o, "data processing without flag update");
            check(reg_write_o == !(code inside {4'h8, 4'hA, 4'hB}),
                $sformatf("data processing code %h has wrong register write", code));
            check(!stall_o, "data processing stalled");
            if (code == 4'h9) begin
                check(alu_a_sel_o == SRC_ZERO, "negate must take zero as operand A");
            end
        end
    endtask

    task automatic cover_shift_immediate();
        instr_t word;
        for (int k = 0; k < 12; k++) begin
            word = {3'b000, 2'(k % 3), 11'($random(seed))};
            drive(word);
            @(negedge clk_i);
            check(alu_b_sel_o == SRC_IMM, "immediate shift must use the immediate as B");
            check(alu_op_o == ((k % 3 == 0) ? ALU_LSL : (k % 3 == 1) ? ALU_LSR : ALU_ASR),
                "immediate shift has wrong ALU op");
            drive({5'b00100, 11'($random(seed))});
            @(negedge clk_i);
            check(alu_a_sel_o == SRC_ZERO && alu_b_sel_o == SRC_IMM,
                "move immediate must add the immediate to zero");
            drive({5'b00101, 11'($random(seed))});
            @(negedge clk_i);
            check(alu_op_o == ALU_SUB && !reg_write_o && update_flags_o,
                "compare immediate must subtract, set flags and not write");
        end
    endtask

    task automatic expect_single_transfer(input logic is_load);
        check(!stall_o && valid_o, "single load/store stalled or was invalid");
        check(src_addr_src_o == ADDR_FROM_INSTR && dest_addr_src_o == ADDR_FROM_INSTR,
            "single load/store must take register numbers from the instruction");
        if (is_load) begin
            check(mem_read_o && reg_write_o && !mem_write_o, "load enables are wrong");
            check(reg_data_src_o == DATA_FROM_MEM, "load must write memory data");
        end else begin
            check(mem_write_o && !reg_write_o && !mem_read_o, "store enables are wrong");
        end
    endtask

    task automatic probe_load_store();
        instr_t word;
        for (int opc = 0; opc < 8; opc++) begin
            word = {4'b0101, 3'(opc), 9'($random(seed))};
            drive(word);
            @(negedge clk_i);
            // opcodes 3 and above are loads, sign-extending ones included
            expect_single_transfer(opc >= 3);
            if (opc < 3) begin
                check(store_sel_o, "register-offset store must take register 3 as data");
            end
        end
        for (int k = 0; k < 16; k++) begin
            word = instr_t'($random(seed));
            word[15:12] = (k % 2 == 1) ? 4'b1000 : {3'b011, word[12]};
            drive(word);
            @(negedge clk_i);
            expect_single_transfer(word[11]);
            check(alu_b_sel_o == SRC_IMM, "immediate load/store must use the immediate as B");
        end
    endtask

    task automatic run_multiple(input logic load, input reg_list_t list, input logic [2:0] base);
        reg_addr_t order[$];
        int        n;
        int        p;
        order = {};
        for (int r = 0; r < `LIST_WIDTH; r++) begin
            if (list[r]) begin
                order.push_back(reg_addr_t'(r));
            end
        end
        n = order.size();
        drive({4'b1100, load, base, list});
        for (int i = 0; i < n; i++) begin
            // loads walk downwards while each register keeps its ascending slot in memory
            p = load ? (n - 1 - i) : i;
            @(negedge clk_i);
            check(stall_o, $sformatf("list %h stalled for only %0d of %0d cycles", list, i, n));
            check(reg_addr_o == order[p],
                $sformatf("list %h step %0d gave r%0d, expected r%0d",
                    list, i, reg_addr_o, order[p]));
            check(offset_o == word_t'(`WORD_BYTES * p),
                $sformatf("list %h step %0d gave offset %0d", list, i, offset_o));
            if (load) begin
                check(mem_read_o && reg_write_o && reg_data_src_o == DATA_FROM_MEM,
                    "load-multiple step must read memory into the register");
                check(dest_addr_src_o == ADDR_FROM_CTRL && src_addr_src_o == ADDR_FROM_INSTR,
                    "load-multiple step must write the sequenced register");
            end else begin
                check(mem_write_o && !reg_write_o, "store-multiple step must write memory");
                check(src_addr_src_o == ADDR_FROM_CTRL && dest_addr_src_o == ADDR_FROM_INSTR,
                    "store-multiple step must read the sequenced register");
            end
        end
        @(negedge clk_i);
        check(!stall_o, $sformatf("list %h still stalled after %0d cycles", list, n));
        check(offset_o == word_t'(`WORD_BYTES * n), "final offset must cover the whole block");
        check(reg_addr_o == reg_addr_t'(base), "final cycle must address the base register");
        check(dest_addr_src_o == ADDR_FROM_CTRL,
            "final cycle must take the base register number from the control unit");
        check(reg_write_o == !(load && list[base]), "base write-back is wrong");
    endtask

    task automatic reject_invalid_opcodes();
        instr_t word;
        for (int k = 0; k < 21; k++) begin
            word = instr_t'($random(seed));
            case (k % 7)
                0: word[15:10] = 6'b010001;
                1: word[15:11] = 5'b01001;
                2: word[15:12] = 4'hA;
                3: word[15:12] = 4'hB;
                4: word[15:12] = 4'hD;
                default: word[15:13] = 3'b111;
            endcase
            drive(word);
            @(negedge clk_i);
            check(!valid_o, $sformatf("opcode %h decoded as valid", word));
            check(!(reg_write_o || mem_read_o || mem_write_o || update_flags_o || stall_o),
                $sformatf("opcode %h enabled a control", word));
        end
    endtask

    initial begin
        reset_i = 1'b1;
        // miscellaneous group, not decoded by this unit
        instruction_i = 16'hB000;
        repeat (8) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        sweep_data_processing();
        cover_shift_immediate();
        probe_load_store();
        run_multiple(1'b0, 8'h00, 3'd0);
        run_multiple(1'b0, 8'hFF, 3'd2);
        for (int k = 0; k < 20; k++) begin
            run_multiple(1'b0, reg_list_t'($random(seed)), 3'($random(seed)));
        end
        for (int k = 0; k < 20; k++) begin
            run_multiple(1'b1, reg_list_t'($random(seed)), 3'($random(seed)));
        end
        run_multiple(1'b1, 8'h0F, 3'd1);
        run_multiple(1'b1, 8'hF0, 3'd1);
        reject_invalid_opcodes();
        @(negedge clk_i);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: thumb_controller.f
+incdir+logic
logic/thumb_ctrl_pkg.sv
logic/multi_reg_if.sv
logic/alu_op_decoder.sv
logic/mem_op_decoder.sv
logic/reg_list_sequencer.sv
logic/thumb_controller.sv
testbench/tb_thumb_controller.sv
